/* accel_defs.svh */
////////////////////////////////////////////////////////////
// Accelerator widths and soft reset timing
////////////////////////////////////////////////////////////

`ifndef ACCEL_DEFS_SVH
`define ACCEL_DEFS_SVH

// Data word and match key
`define ACCEL_DATA_W 32

// Job length in words
`define ACCEL_LEN_W 16

// Statistics counters
`define ACCEL_STAT_W 32

// Soft reset low time in clock cycles
`define ACCEL_SOFT_RESET_CYCLES 4

`endif

/* accel_pkg.sv */
////////////////////////////////////////////////////////////
// Accelerator types shared by the compute unit and the
// completion controller
////////////////////////////////////////////////////////////

`default_nettype none

`include "accel_defs.svh"

package accel_pkg;

	// Job opcode
	typedef enum logic {
		OP_SUM   = 1'b0,
		OP_MATCH = 1'b1
	} cu_op_t;

	// Completion controller states
	typedef enum logic [2:0] {
		DONE_RESET         = 3'd0,
		DONE_IDLE          = 3'd1,
		DONE_RESET_REQ     = 3'd2,
		DONE_RESET_PENDING = 3'd3,
		DONE_MMIO_REQ      = 3'd4
	} done_state_t;

	////////////////////////////////////////////////////////////
	// Compute unit return word
	////////////////////////////////////////////////////////////

	// Same 64 bits, decoded by the job opcode
	// SUM reads the whole word as one total
	// MATCH reads match count in the upper half
	typedef union packed {
		logic [2*`ACCEL_DATA_W-1:0] sum_view;
		struct packed {
			logic [`ACCEL_DATA_W-1:0] match_count;
			logic [`ACCEL_DATA_W-1:0] word_count;
		} match_view;
	} cu_return_t;

endpackage

`default_nettype wire

/* compute_unit.sv */
////////////////////////////////////////////////////////////
// Compute unit: takes one job and its data stream, reduces
// the words to a sum or a match count, then raises done
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "accel_defs.svh"

module compute_unit (
	input  wire logic                     clock,
	input  wire logic                     rstn,
	input  wire logic                     soft_rstn,
	input  wire logic                     job_valid,
	output logic                          job_ready,
	input  wire accel_pkg::cu_op_t        job_op,
	input  wire logic [`ACCEL_LEN_W-1:0]  job_len,
	input  wire logic [`ACCEL_DATA_W-1:0] job_key,
	input  wire logic                     data_valid,
	output logic                          data_ready,
	input  wire logic [`ACCEL_DATA_W-1:0] data_word,
	input  wire logic                     accept_jobs,
	output logic                          busy,
	output logic                          done,
	output accel_pkg::cu_return_t         cu_return,
	output accel_pkg::cu_op_t             op
);

	import accel_pkg::*;

	// State encoding
	localparam logic [1:0] CU_IDLE = 2'd0;
	localparam logic [1:0] CU_RUN  = 2'd1;
	localparam logic [1:0] CU_FIN  = 2'd2;

	logic [1:0]                state;
	logic [`ACCEL_LEN_W-1:0]   remaining;
	logic [`ACCEL_DATA_W-1:0]  key;
	logic [2*`ACCEL_DATA_W-1:0] sum_acc;
	logic [`ACCEL_DATA_W-1:0]  match_cnt;
	logic [`ACCEL_DATA_W-1:0]  word_cnt;
	logic                      job_fire;
	logic                      data_fire;

	// Only idle, out of soft reset, and with no result pending
	assign job_ready  = (state == CU_IDLE) && soft_rstn && accept_jobs;
	assign job_fire   = job_valid && job_ready;
	assign busy       = (state == CU_RUN);
	assign data_ready = busy;
	assign data_fire  = data_valid && data_ready;
	assign done       = (state == CU_FIN);

	////////////////////////////////////////////////////////////
	// Job FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state     <= CU_IDLE;
			remaining <= '0;
			op        <= OP_SUM;
		end else if (!soft_rstn) begin
			state     <= CU_IDLE;
			remaining <= '0;
		end else begin
			case (state)
				CU_IDLE: begin
					if (job_fire) begin
						op        <= job_op;
						remaining <= job_len;
						// Empty job finishes at once
						state     <= (job_len == '0) ? CU_FIN : CU_RUN;
					end
				end
				CU_RUN: begin
					if (data_fire) begin
						remaining <= remaining - 1'b1;
						if (remaining == 1)
							state <= CU_FIN;
					end
				end
				// Held until soft reset
				CU_FIN: state <= CU_FIN;
				default: state <= CU_IDLE;
			endcase
		end
	end

	// Accumulators, cleared per job
	always_ff @(posedge clock) begin
		if (!soft_rstn || job_fire) begin
			sum_acc   <= '0;
			match_cnt <= '0;
			word_cnt  <= '0;
			key       <= job_key;
		end else if (data_fire) begin
			sum_acc  <= sum_acc + {{`ACCEL_DATA_W{1'b0}}, data_word};
			word_cnt <= word_cnt + 1'b1;
			if (data_word == key)
				match_cnt <= match_cnt + 1'b1;
		end
	end

	// Return word view picked by opcode
	always_comb begin
		cu_return.sum_view = sum_acc;
		if (op == OP_MATCH) begin
			cu_return.match_view.match_count = match_cnt;
			cu_return.match_view.word_count  = word_cnt;
		end
	end

endmodule

`default_nettype wire

/* response_counter.sv */
////////////////////////////////////////////////////////////
// Job statistics: accepted words, stalls and busy cycles
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "accel_defs.svh"

module response_counter (
	input  wire logic                     clock,
	input  wire logic                     rstn,
	input  wire logic                     soft_rstn,
	input  wire logic                     busy,
	input  wire logic                     data_valid,
	input  wire logic                     data_ready,
	output logic [`ACCEL_STAT_W-1:0]      stat_words,
	output logic [`ACCEL_STAT_W-1:0]      stat_stalls,
	output logic [`ACCEL_STAT_W-1:0]      stat_cycles
);

	// Increment that sticks at all ones
	function automatic logic [`ACCEL_STAT_W-1:0] sat_inc(
		input logic [`ACCEL_STAT_W-1:0] value
	);
		if (&value)
			return value;
		return value + 1'b1;
	endfunction

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			stat_words  <= '0;
			stat_stalls <= '0;
			stat_cycles <= '0;
		end else if (!soft_rstn) begin
			// Cleared between jobs
			stat_words  <= '0;
			stat_stalls <= '0;
			stat_cycles <= '0;
		end else if (busy) begin
			stat_cycles <= sat_inc(stat_cycles);
			// Word accepted on handshake
			if (data_valid && data_ready)
				stat_words <= sat_inc(stat_words);
			// Source had nothing to give
			if (!data_valid)
				stat_stalls <= sat_inc(stat_stalls);
		end
	end

endmodule

`default_nettype wire

/* soft_reset_ctrl.sv */
////////////////////////////////////////////////////////////
// Soft reset sequencer: a low request pulse gives a soft
// reset held low for a fixed number of cycles
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "accel_defs.svh"

module soft_reset_ctrl (
	input  wire logic clock,
	input  wire logic rstn,
	input  wire logic reset_done,
	output logic      soft_rstn
);

	localparam int CNT_W = $clog2(`ACCEL_SOFT_RESET_CYCLES + 1);

	logic [CNT_W-1:0] count;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			soft_rstn <= 1'b1;
			count     <= '0;
		end else if (!reset_done) begin
			// New request, also restarts a running reset
			soft_rstn <= 1'b0;
			count     <= CNT_W'(`ACCEL_SOFT_RESET_CYCLES - 1);
		end else if (!soft_rstn) begin
			if (count == '0)
				soft_rstn <= 1'b1;
			else
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

/* done_control.sv */
////////////////////////////////////////////////////////////
// Completion FSM: latches result and statistics, runs the
// soft reset, then offers the result to the host
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "accel_defs.svh"

module done_control (
	input  wire logic                     clock,
	input  wire logic                     rstn,
	input  wire logic                     soft_rstn,
	input  wire logic                     enable,
	input  wire logic                     cu_done,
	input  wire accel_pkg::cu_op_t        cu_op,
	input  wire accel_pkg::cu_return_t    cu_return,
	input  wire logic [`ACCEL_STAT_W-1:0] stat_words,
	input  wire logic [`ACCEL_STAT_W-1:0] stat_stalls,
	input  wire logic [`ACCEL_STAT_W-1:0] stat_cycles,
	input  wire logic                     result_ready,
	output logic                          reset_done,
	output logic                          idle,
	output logic                          result_valid,
	output accel_pkg::cu_op_t             result_op,
	output accel_pkg::cu_return_t         result,
	output logic [`ACCEL_STAT_W-1:0]      out_words,
	output logic [`ACCEL_STAT_W-1:0]      out_stalls,
	output logic [`ACCEL_STAT_W-1:0]      out_cycles
);

	import accel_pkg::*;

	logic        rstn_q;
	logic        enable_q;
	logic        soft_meta;
	logic        soft_sync;
	logic        soft_rise;
	done_state_t state;
	done_state_t next_state;

	// Local reset, one cycle late on release
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			rstn_q <= 1'b0;
		else
			rstn_q <= 1'b1;
	end

	////////////////////////////////////////////////////////////
	// Soft reset sync and enable
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn_q) begin
		if (!rstn_q) begin
			soft_meta <= 1'b1;
			soft_sync <= 1'b1;
			soft_rise <= 1'b0;
			enable_q  <= 1'b0;
		end else begin
			soft_meta <= soft_rstn;
			soft_sync <= soft_meta;
			// Release of soft reset
			soft_rise <= soft_meta && !soft_sync;
			enable_q  <= enable;
		end
	end

	////////////////////////////////////////////////////////////
	// Completion FSM
	////////////////////////////////////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			DONE_RESET:         next_state = DONE_IDLE;
			DONE_IDLE:          if (cu_done) next_state = DONE_RESET_REQ;
			DONE_RESET_REQ:     next_state = DONE_RESET_PENDING;
			DONE_RESET_PENDING: if (soft_rise) next_state = DONE_MMIO_REQ;
			DONE_MMIO_REQ:      if (result_ready) next_state = DONE_IDLE;
			default:            next_state = DONE_RESET;
		endcase
	end

	// Gated by last cycle's enable
	// Host handshake always completes so valid never repeats a transfer
	always_ff @(posedge clock or negedge rstn_q) begin
		if (!rstn_q)
			state <= DONE_RESET;
		else if (enable_q || (state == DONE_MMIO_REQ && result_ready))
			state <= next_state;
	end

	// One cycle low pulse, only when leaving RESET_REQ
	always_ff @(posedge clock or negedge rstn_q) begin
		if (!rstn_q)
			reset_done <= 1'b1;
		else
			reset_done <= !(state == DONE_RESET_REQ && enable_q);
	end

	// Track live values while idle, frozen afterwards
	always_ff @(posedge clock) begin
		if (state == DONE_IDLE) begin
			result     <= cu_return;
			result_op  <= cu_op;
			out_words  <= stat_words;
			out_stalls <= stat_stalls;
			out_cycles <= stat_cycles;
		end
	end

	assign idle         = (state == DONE_IDLE);
	assign result_valid = (state == DONE_MMIO_REQ);

endmodule

`default_nettype wire

/* accel_top.sv */
////////////////////////////////////////////////////////////
// Job accelerator top: compute unit, statistics, soft
// reset sequencer and completion controller
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "accel_defs.svh"

module accel_top (
	input  wire logic                     clock,
	input  wire logic                     rstn,
	input  wire logic                     enable,
	// Job port
	input  wire logic                     job_valid,
	output logic                          job_ready,
	input  wire accel_pkg::cu_op_t        job_op,
	input  wire logic [`ACCEL_LEN_W-1:0]  job_len,
	input  wire logic [`ACCEL_DATA_W-1:0] job_key,
	// Data port
	input  wire logic                     data_valid,
	output logic                          data_ready,
	input  wire logic [`ACCEL_DATA_W-1:0] data_word,
	// Result port
	output logic                          result_valid,
	input  wire logic                     result_ready,
	output accel_pkg::cu_op_t             result_op,
	output accel_pkg::cu_return_t         result,
	output logic [`ACCEL_STAT_W-1:0]      stat_words,
	output logic [`ACCEL_STAT_W-1:0]      stat_stalls,
	output logic [`ACCEL_STAT_W-1:0]      stat_cycles
);

	import accel_pkg::*;

	logic                     cu_busy;
	logic                     cu_done;
	cu_return_t               cu_return;
	cu_op_t                   cu_op;
	logic                     cu_soft_rstn;
	logic                     reset_done;
	logic                     ctrl_idle;
	logic [`ACCEL_STAT_W-1:0] cnt_words;
	logic [`ACCEL_STAT_W-1:0] cnt_stalls;
	logic [`ACCEL_STAT_W-1:0] cnt_cycles;

	compute_unit compute_unit_i (
		.clock, .rstn, .soft_rstn(cu_soft_rstn),
		.job_valid, .job_ready, .job_op, .job_len, .job_key,
		.data_valid, .data_ready, .data_word,
		.accept_jobs(ctrl_idle), .busy(cu_busy), .done(cu_done),
		.cu_return, .op(cu_op)
	);

	// Statistics watch the data handshake during busy
	response_counter response_counter_i (
		.clock, .rstn, .soft_rstn(cu_soft_rstn), .busy(cu_busy),
		.data_valid, .data_ready,
		.stat_words(cnt_words), .stat_stalls(cnt_stalls), .stat_cycles(cnt_cycles)
	);

	soft_reset_ctrl soft_reset_ctrl_i (
		.clock, .rstn, .reset_done, .soft_rstn(cu_soft_rstn)
	);

	done_control done_control_i (
		.clock, .rstn, .soft_rstn(cu_soft_rstn), .enable,
		.cu_done, .cu_op, .cu_return,
		.stat_words(cnt_words), .stat_stalls(cnt_stalls), .stat_cycles(cnt_cycles),
		.result_ready, .reset_done, .idle(ctrl_idle),
		.result_valid, .result_op, .result,
		.out_words(stat_words), .out_stalls(stat_stalls), .out_cycles(stat_cycles)
	);

endmodule

`default_nettype wire

/* accel_properties.sv */
////////////////////////////////////////////////////////////
// Accelerator assertions on result handshake and soft reset
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "accel_defs.svh"

module accel_properties (
	input wire logic                     clock,
	input wire logic                     rstn,
	input wire logic                     job_ready,
	input wire logic                     result_valid,
	input wire logic                     result_ready,
	input wire accel_pkg::cu_op_t        result_op,
	input wire accel_pkg::cu_return_t    result,
	input wire logic [`ACCEL_STAT_W-1:0] stat_words,
	input wire logic [`ACCEL_STAT_W-1:0] stat_stalls,
	input wire logic [`ACCEL_STAT_W-1:0] stat_cycles,
	input wire logic                     reset_done
);

	// Back-pressured result keeps valid and every field
	held_result: assert property (@(posedge clock) disable iff (!rstn)
		result_valid && !result_ready |=> result_valid && $stable(result)
		&& $stable(result_op) && $stable(stat_words) && $stable(stat_stalls)
		&& $stable(stat_cycles))
		else $error("result port changed while result_ready was low");

	// No new job while a result waits for the host
	no_job_while_pending: assert property (@(posedge clock) disable iff (!rstn)
		result_valid |-> !job_ready)
		else $error("job_ready high while result_valid high");

	// Soft reset request is a single cycle low pulse
	reset_req_pulse: assert property (@(posedge clock) disable iff (!rstn)
		!reset_done |=> reset_done)
		else $error("reset_done low for more than one cycle");

endmodule

bind accel_top accel_properties accel_properties_i (
	.clock, .rstn, .job_ready, .result_valid, .result_ready, .result_op, .result,
	.stat_words, .stat_stalls, .stat_cycles, .reset_done
);

`default_nettype wire

/* accel_tb.sv */
////////////////////////////////////////////////////////////
// Accelerator testbench drives a table of jobs through the
// job and data ports and checks results per entry
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "accel_defs.svh"

module accel_tb;

	import accel_pkg::*;

	localparam int NUM_TESTS = 7;
	localparam int TIMEOUT   = 200;
	localparam int LEN_W     = `ACCEL_LEN_W;

	logic                     clock;
	logic                     rstn;
	logic                     enable;
	logic                     job_valid;
	logic                     job_ready;
	cu_op_t                   job_op;
	logic [`ACCEL_LEN_W-1:0]  job_len;
	logic [`ACCEL_DATA_W-1:0] job_key;
	logic                     data_valid;
	logic                     data_ready;
	logic [`ACCEL_DATA_W-1:0] data_word;
	logic                     result_valid;
	logic                     result_ready;
	cu_op_t                   result_op;
	cu_return_t               result;
	logic [`ACCEL_STAT_W-1:0] stat_words;
	logic [`ACCEL_STAT_W-1:0] stat_stalls;
	logic [`ACCEL_STAT_W-1:0] stat_cycles;

	// One row per job with name, opcode, length, key, data seed,
	// gap pattern, result_ready delay and enable hold cycles
	string       t_name  [NUM_TESTS] = '{"sum_basic", "match_basic", "sum_gaps",
		"match_backpressure", "sum_enable_hold", "match_gaps_hold", "sum_back_to_back"};
	cu_op_t      t_op    [NUM_TESTS] = '{OP_SUM, OP_MATCH, OP_SUM, OP_MATCH, OP_SUM,
		OP_MATCH, OP_SUM};
	int          t_len   [NUM_TESTS] = '{8, 12, 10, 9, 6, 16, 3};
	logic [31:0] t_key   [NUM_TESTS] = '{32'd0, 32'd3, 32'd0, 32'd5, 32'd0, 32'd1, 32'd0};
	logic [31:0] t_seed  [NUM_TESTS] = '{32'h0, 32'h11, 32'h22, 32'h33, 32'h44, 32'h55, 32'h66};
	logic [15:0] t_gap   [NUM_TESTS] = '{16'h0000, 16'h0000, 16'h9c26, 16'h0404, 16'h0010,
		16'h3001, 16'h0000};
	int          t_delay [NUM_TESTS] = '{0, 0, 0, 6, 2, 3, 0};
	int          t_hold  [NUM_TESTS] = '{0, 0, 0, 0, 12, 14, 0};

	logic [31:0] words [64];
	logic [63:0] exp_sum;
	int          exp_match;
	int          exp_stalls;
	int          cur;
	int          test_errors;
	int          pass_count;
	int          fail_count;
	bit          hung;

	accel_top accel_top_i (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	// LCG step with full period over 32 bits
	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Idle cycles before word w from two bits per word
	// Pattern repeats every eight words
	function automatic int gap_before(input int idx, input int w);
		return int'(t_gap[idx][2*(w%8) +: 2]);
	endfunction

	// Next rising edge plus drive skew
	task automatic step_cycle();
		@(posedge clock);
		#1;
	endtask

	task automatic check_field(input string field, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			$display("Error %s %s: expected %0h, actual %0h", t_name[cur], field,
				expected, actual);
			test_errors++;
		end
	endtask

	function automatic logic probe(input string name);
		if (name == "job_ready")
			return job_ready;
		if (name == "data_ready")
			return data_ready;
		return result_valid;
	endfunction

	// Poll at falling edges where DUT outputs are settled
	task automatic wait_high(input string name);
		int n;
		n = 0;
		@(negedge clock);
		while (!probe(name) && n < TIMEOUT) begin
			@(negedge clock);
			n++;
		end
		if (!probe(name)) begin
			$display("Timeout in %s: %s never went high", t_name[cur], name);
			hung = 1'b1;
		end
	endtask

	////////////////////////////////////////////////////////////
	// One table entry
	////////////////////////////////////////////////////////////

	task automatic run_test(input int idx);
		logic [31:0] lcg;
		cu_return_t  held;
		lcg        = 32'h24eb5e82 ^ t_seed[idx];
		exp_sum    = '0;
		exp_match  = 0;
		exp_stalls = 0;
		// Words and expected values from the same stream
		for (int w = 0; w < t_len[idx]; w++) begin
			lcg = lcg_next(lcg);
			// Small range for MATCH so the key shows up
			words[w] = (t_op[idx] == OP_MATCH) ? {29'd0, lcg[18:16]} : lcg;
			exp_sum += {32'd0, words[w]};
			if (words[w] == t_key[idx])
				exp_match++;
			exp_stalls += gap_before(idx, w);
		end
		// Enable low keeps the controller from leaving idle
		if (t_hold[idx] > 0)
			enable = 1'b0;
		job_valid = 1'b1;
		job_op    = t_op[idx];
		job_len   = LEN_W'(t_len[idx]);
		job_key   = t_key[idx];
		wait_high("job_ready");
		if (hung)
			return;
		step_cycle();
		job_valid = 1'b0;
		for (int w = 0; w < t_len[idx]; w++) begin
			repeat (gap_before(idx, w))
				step_cycle();
			data_valid = 1'b1;
			data_word  = words[w];
			wait_high("data_ready");
			if (hung)
				return;
			step_cycle();
			data_valid = 1'b0;
		end
		// Nothing may come out during the hold
		for (int h = 0; h < t_hold[idx]; h++) begin
			@(negedge clock);
			check_field("result_valid during hold", 64'd0, 64'(result_valid));
			step_cycle();
		end
		enable = 1'b1;
		wait_high("result_valid");
		if (hung)
			return;
		check_field("result_op", 64'(t_op[idx]), 64'(result_op));
		if (t_op[idx] == OP_SUM) begin
			check_field("sum", exp_sum, result.sum_view);
		end else begin
			check_field("match count", 64'(exp_match), 64'(result.match_view.match_count));
			check_field("word count", 64'(t_len[idx]), 64'(result.match_view.word_count));
		end
		check_field("stat_words", 64'(t_len[idx]), 64'(stat_words));
		check_field("stat_stalls", 64'(exp_stalls), 64'(stat_stalls));
		check_field("stat_cycles", 64'(t_len[idx] + exp_stalls), 64'(stat_cycles));
		// Host stalls, result holds and job port stays closed
		held = result;
		for (int d = 0; d < t_delay[idx]; d++) begin
			step_cycle();
			@(negedge clock);
			check_field("held result_valid", 64'd1, 64'(result_valid));
			check_field("held result", held, result);
			check_field("held result_op", 64'(t_op[idx]), 64'(result_op));
			check_field("held stat_words", 64'(t_len[idx]), 64'(stat_words));
			check_field("held stat_stalls", 64'(exp_stalls), 64'(stat_stalls));
			check_field("held stat_cycles", 64'(t_len[idx] + exp_stalls), 64'(stat_cycles));
			check_field("job_ready while held", 64'd0, 64'(job_ready));
		end
		step_cycle();
		result_ready = 1'b1;
		step_cycle();
		result_ready = 1'b0;
	endtask

	initial begin
		rstn         = 1'b0;
		enable       = 1'b1;
		job_valid    = 1'b0;
		job_op       = OP_SUM;
		job_len      = '0;
		job_key      = '0;
		data_valid   = 1'b0;
		data_word    = '0;
		result_ready = 1'b0;
		hung         = 1'b0;
		pass_count   = 0;
		fail_count   = 0;
		repeat (10) @(posedge clock);
		#1;
		rstn = 1'b1;
		for (cur = 0; cur < NUM_TESTS && !hung; cur++) begin
			test_errors = 0;
			run_test(cur);
			if (!hung && test_errors == 0) begin
				$display("PASS %s", t_name[cur]);
				pass_count++;
			end else begin
				$display("FAIL %s with %0d errors%s", t_name[cur], test_errors,
					hung ? ", stopped on timeout" : "");
				fail_count++;
			end
		end
		$display("Tests run %0d, passed %0d, failed %0d", pass_count + fail_count,
			pass_count, fail_count);
		if (fail_count == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
accel_pkg.sv
compute_unit.sv
response_counter.sv
soft_reset_ctrl.sv
done_control.sv
accel_top.sv
accel_properties.sv
accel_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the accelerator testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module accel_tb -f verilog.f \
	-Mdir obj_dir -o accel_sim; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/accel_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "TESTBENCH PASSED"; then
	exit 0
fi
exit 1
